// File: verilog.f
scan_pkg.sv
stream_context.sv
dfa_step.sv
match_accumulate.sv
scan_top.sv
tb_scan.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_scan
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

// File: tb_scan.sv
`timescale 1ns/1ps

module tb_scan;
  import scan_pkg::*;

  // Narrow counter so the random run wraps it
  localparam int COUNT_W    = 3;
  localparam int MAX_PKTS   = 512;
  localparam int WAIT_LIMIT = 100;

  logic               clk;
  logic               rst_n;
  beat_t              in_beat;
  result_t            result;
  logic [COUNT_W-1:0] count;
  logic               fired;

  scan_top #(
    .COUNT_W (COUNT_W)
  ) dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_beat (in_beat),
    .result  (result),
    .count   (count),
    .fired   (fired)
  );

  // Reference model, per-stream saved state and previous packet
  dfa_state_t          saved_state [NUM_STREAMS];
  logic                known [NUM_STREAMS];
  dfa_state_t          live_state;
  logic                prev_vld;
  logic [STREAM_W-1:0] prev_stream;
  logic                prev_enable;
  logic [COUNT_W-1:0]  model_count;
  // Expected packet flag of the beat being driven
  logic                exp_fire;

  // Expected results in packet order
  logic [STREAM_W-1:0] exp_stream [MAX_PKTS];
  logic                exp_matched [MAX_PKTS];
  logic [COUNT_W-1:0]  exp_count [MAX_PKTS];
  int                  exp_total;
  int                  res_idx;

  // Expected flags shifted along with the DUT stages
  logic [2:0] fire_d;
  logic [3:0] eop_d;

  // Bytes of the next packet
  logic [7:0] pkt_q [$];

  int   err_cnt;
  int   pass_cnt;
  int   fail_cnt;
  logic hung;

  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  // Results seen so far
  always @(posedge clk)
  begin
    if (!rst_n)
      res_idx <= 0;
    else if (result.vld)
      res_idx <= res_idx + 1;
  end

  // Beat taken at edge k is in stage 3 after k+2, its result after k+3
  always @(posedge clk)
  begin
    fire_d <= {fire_d[1:0], in_beat.vld && exp_fire};
    eop_d  <= {eop_d[2:0], in_beat.vld && in_beat.eop};
  end

  // End of packet report against the model
  result_check: assert property (@(posedge clk) disable iff (!rst_n)
    result.vld |-> (res_idx < exp_total && result.stream == exp_stream[res_idx] &&
                    result.matched == exp_matched[res_idx]))
  else
  begin
    err_cnt++;
    $display("error %0t: end of packet result differs from model", $time);
  end

  // Result pulse lands a fixed three edges after the eop beat
  result_timing: assert property (@(posedge clk) disable iff (!rst_n)
    result.vld == eop_d[3])
  else
  begin
    err_cnt++;
    $display("error %0t: result pulse out of step with end of packet", $time);
  end

  // Count has taken the packet in the cycle its result shows
  count_check: assert property (@(posedge clk) disable iff (!rst_n)
    result.vld |-> count == exp_count[res_idx])
  else
  begin
    err_cnt++;
    $display("error %0t: match count differs from model", $time);
  end

  // Packet flag of the beat now in stage 3
  fired_check: assert property (@(posedge clk) disable iff (!rst_n)
    fired == fire_d[2])
  else
  begin
    err_cnt++;
    $display("error %0t: fired flag differs from model", $time);
  end

  // One byte step of "GROUP " matching
  function automatic dfa_state_t model_step(input dfa_state_t st, input logic [7:0] data,
                                            output logic acc);
    string      kw;
    logic [7:0] c;
    kw  = "GROUP ";
    c   = data;
    acc = 1'b0;
    // Clearing bit 5 upper-cases a letter
    if (c inside {["a":"z"]})
      c[5] = 1'b0;
    if (c == kw[st])
    begin
      if (st == 3'd5)
      begin
        acc = 1'b1;
        return ST_IDLE;
      end
      return st + 3'd1;
    end
    // A G restarts the keyword
    if (c == "G")
      return 3'd1;
    return ST_IDLE;
  endfunction

  task automatic load_text(input string s);
    pkt_q.delete();
    for (int i = 0; i < s.len(); i++)
      pkt_q.push_back(s[i]);
  endtask

  // Keyword characters a..b in random case
  task automatic push_fragment(input int a, input int b);
    string      kw;
    logic [7:0] c;
    kw = "GROUP ";
    for (int j = a; j <= b; j++)
    begin
      c = kw[j];
      if ($urandom_range(1) == 1)
        c = c | 8'h20;
      pkt_q.push_back(c);
    end
  endtask

  // Noise from keyword letters, keyword prefix at the end or suffix at the start
  task automatic load_random();
    string noise;
    int    len;
    logic  use_frag;
    logic  at_end;
    int    a;
    int    b;
    noise    = "GROUPgroup xz.";
    use_frag = ($urandom_range(2) != 0);
    at_end   = 1'($urandom_range(1));
    a        = 0;
    b        = 5;
    if (at_end)
      b = $urandom_range(5, 2);
    else
      a = $urandom_range(5, 1);
    pkt_q.delete();
    if (use_frag && !at_end)
      push_fragment(a, b);
    len = $urandom_range(6);
    for (int i = 0; i < len; i++)
      pkt_q.push_back(noise[$urandom_range(noise.len() - 1)]);
    if (use_frag && at_end)
      push_fragment(a, b);
    if (pkt_q.size() == 0)
      pkt_q.push_back(noise[$urandom_range(noise.len() - 1)]);
  endtask

  // Drive pkt_q as one packet and record what the model expects
  task automatic send_packet(input logic [STREAM_W-1:0] stream, input logic new_stream,
                             input logic enable, input int intent);
    beat_t      b;
    dfa_state_t st;
    logic       acc;
    logic       hit;
    logic       matched;
    // Live state, then fresh start, then saved state
    if (prev_vld && prev_enable && prev_stream == stream && !new_stream)
      st = live_state;
    else if (new_stream)
      st = ST_IDLE;
    else
      st = saved_state[stream];
    hit = 1'b0;
    for (int i = 0; i < pkt_q.size(); i++)
    begin
      b.vld        = 1'b1;
      b.data       = pkt_q[i];
      b.sop        = (i == 0);
      b.eop        = (i == pkt_q.size() - 1);
      b.stream     = stream;
      b.new_stream = new_stream;
      b.enable     = enable;
      @(posedge clk);
      in_beat <= b;
      st  = model_step(st, pkt_q[i], acc);
      hit = hit | acc;
      exp_fire <= hit;
    end
    live_state  = st;
    prev_vld    = 1'b1;
    prev_stream = stream;
    prev_enable = enable;
    // Disabled packets leave the saved state alone
    if (enable)
    begin
      saved_state[stream] = st;
      known[stream]       = 1'b1;
    end
    matched                = hit && enable;
    model_count            = model_count + COUNT_W'(matched);
    exp_stream[exp_total]  = stream;
    exp_matched[exp_total] = matched;
    exp_count[exp_total]   = model_count;
    exp_total++;
    if (intent >= 0)
      assert (int'(matched) == intent)
      else
      begin
        err_cnt++;
        $display("error %0t: stream %0d matched %0b, test expects %0d",
                 $time, stream, matched, intent);
      end
  endtask

  // Drain the pipeline and print the test line
  task automatic finish_test(input string name, input int errs);
    int n;
    @(posedge clk);
    in_beat <= '0;
    n = 0;
    while (res_idx != exp_total && n < WAIT_LIMIT)
    begin
      @(posedge clk);
      n++;
    end
    if (res_idx != exp_total)
    begin
      hung = 1'b1;
      $display("Timeout in %s, only %0d of %0d results came out", name, res_idx, exp_total);
    end
    // Let the checks on the last result run
    @(posedge clk);
    if (!hung && err_cnt == errs)
    begin
      pass_cnt++;
      $display("test %s: pass", name);
    end
    else
    begin
      fail_cnt++;
      $display("test %s: fail", name);
    end
  endtask

  task automatic test_single();
    int errs;
    errs = err_cnt;
    load_text("xx GrOuP now");
    send_packet(6'd1, 1'b1, 1'b1, 1);
    load_text("xx GrOuPnow");
    send_packet(6'd1, 1'b1, 1'b1, 0);
    finish_test("single packet", errs);
  endtask

  task automatic test_split();
    int errs;
    errs = err_cnt;
    // Back to back, live state carries over
    load_text("hdr GRO");
    send_packet(6'd2, 1'b1, 1'b1, 0);
    load_text("UP x");
    send_packet(6'd2, 1'b0, 1'b1, 1);
    finish_test("split resume", errs);
    // One beat of another stream, saved state comes via the write forward
    errs = err_cnt;
    load_text("a gro");
    send_packet(6'd3, 1'b1, 1'b1, 0);
    load_text("z");
    send_packet(6'd4, 1'b1, 1'b1, 0);
    load_text("uP b");
    send_packet(6'd3, 1'b0, 1'b1, 1);
    finish_test("split restore", errs);
    errs = err_cnt;
    load_text("GRO");
    send_packet(6'd5, 1'b1, 1'b1, 0);
    load_text("UP ");
    send_packet(6'd5, 1'b1, 1'b1, 0);
    finish_test("split new stream", errs);
  endtask

  task automatic test_disabled();
    int errs;
    errs = err_cnt;
    load_text("GROU");
    send_packet(6'd6, 1'b1, 1'b1, 0);
    // Keyword in a disabled packet is not counted
    load_text("xGROUP ");
    send_packet(6'd6, 1'b0, 1'b0, 0);
    load_text("P ");
    send_packet(6'd6, 1'b0, 1'b1, 1);
    finish_test("disabled stream", errs);
  endtask

  task automatic test_random();
    int                  errs;
    logic [STREAM_W-1:0] s;
    logic                ns;
    logic                en;
    errs = err_cnt;
    for (int p = 0; p < 200; p++)
    begin
      // Mostly four streams so resume and restore both come up
      s = 6'($urandom_range(3));
      if ($urandom_range(4) == 0)
        s = 6'($urandom_range(NUM_STREAMS - 1));
      // A stream with no saved state starts fresh
      ns = !known[s] || ($urandom_range(7) == 0);
      en = ($urandom_range(3) != 0);
      load_random();
      send_packet(s, ns, en, -1);
      repeat ($urandom_range(2))
      begin
        @(posedge clk);
        in_beat <= '0;
      end
    end
    finish_test("random packets", errs);
  endtask

  initial
  begin
    void'($urandom(36453));
    in_beat     <= '0;
    exp_fire    <= 1'b0;
    rst_n       <= 1'b0;
    err_cnt     = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    hung        = 1'b0;
    exp_total   = 0;
    live_state  = ST_IDLE;
    prev_vld    = 1'b0;
    prev_stream = '0;
    prev_enable = 1'b0;
    model_count = '0;
    for (int s = 0; s < NUM_STREAMS; s++)
    begin
      saved_state[s] = ST_IDLE;
      known[s]       = 1'b0;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (!hung)
      test_single();
    if (!hung)
      test_split();
    if (!hung)
      test_disabled();
    if (!hung)
      test_random();
    $display("tests passed %0d failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (!hung && fail_cnt == 0 && err_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: scan_top.sv
`timescale 1ns/1ps

module scan_top #(
  parameter int COUNT_W = 16
) (
  input  logic               clk,
  input  logic               rst_n,
  input  scan_pkg::beat_t    in_beat,
  output scan_pkg::result_t  result,
  output logic [COUNT_W-1:0] count,
  output logic               fired
);
  import scan_pkg::*;

  // Stage 1 to stage 2
  ctx_beat_t ctx_beat;
  // Stage 2 to stage 3
  dfa_beat_t dfa_beat;
  // State save path back to stage 1
  state_wb_t state_wb;

  // Stream context restore
  stream_context stream_context_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_beat  (in_beat),
    .wb       (state_wb),
    .out_beat (ctx_beat)
  );

  // Keyword DFA
  dfa_step dfa_step_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_beat  (ctx_beat),
    .out_beat (dfa_beat),
    .wb       (state_wb)
  );

  // Per-packet result and match count
  match_accumulate #(
    .COUNT_W (COUNT_W)
  ) match_accumulate_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_beat (dfa_beat),
    .result  (result),
    .count   (count),
    .fired   (fired)
  );

endmodule

// File: match_accumulate.sv
`timescale 1ns/1ps

module match_accumulate #(
  parameter int COUNT_W = 16
) (
  input  logic                clk,
  input  logic                rst_n,
  input  scan_pkg::dfa_beat_t in_beat,
  output scan_pkg::result_t   result,
  output logic [COUNT_W-1:0]  count,
  output logic                fired
);

  // Match seen earlier in the current packet
  logic pkt_flag;

  // Flag including this beat, sop drops any stale flag
  logic hit;
  // Contribution of this packet to the count
  logic pkt_match;

  always_comb
  begin
    hit       = in_beat.accept || (pkt_flag && !in_beat.sop);
    pkt_match = hit && in_beat.enable;
  end

  // Live flag of the packet in this stage
  assign fired = in_beat.vld && hit;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pkt_flag   <= 1'b0;
      count      <= '0;
      result.vld <= 1'b0;
    end
    else
    begin
      result.vld <= in_beat.vld && in_beat.eop;
      if (in_beat.vld)
      begin
        if (in_beat.eop)
        begin
          // Finalize the packet, count wraps
          result.stream  <= in_beat.stream;
          result.matched <= pkt_match;
          count          <= count + COUNT_W'(pkt_match);
          pkt_flag       <= 1'b0;
        end
        else
          pkt_flag <= hit;
      end
    end
  end

endmodule

// File: dfa_step.sv
`timescale 1ns/1ps

module dfa_step (
  input  logic                clk,
  input  logic                rst_n,
  input  scan_pkg::ctx_beat_t in_beat,
  output scan_pkg::dfa_beat_t out_beat,
  output scan_pkg::state_wb_t wb
);
  import scan_pkg::*;

  // Live DFA state, carries across packets of one stream
  dfa_state_t cur_state;

  // State the current byte is applied to
  dfa_state_t base_state;
  dfa_state_t next_state;
  logic [7:0] up_char;
  logic       accept;

  always_comb
  begin
    // Packet start takes the restored state unless the live one is newer
    base_state = cur_state;
    if (in_beat.beat.sop && !in_beat.resume)
      base_state = in_beat.start_state;

    // Fold lower case letters to upper case
    up_char = in_beat.beat.data;
    if (up_char >= "a" && up_char <= "z")
      up_char = up_char - 8'h20;

    accept     = 1'b0;
    next_state = ST_IDLE;
    if (base_state > ST_LAST)
      next_state = ST_IDLE;
    else if (up_char == KEYWORD[ST_LAST - base_state])
    begin
      // Expected character
      if (base_state == ST_LAST)
      begin
        accept     = 1'b1;
        next_state = ST_IDLE;
      end
      else
        next_state = base_state + 3'd1;
    end
    else if (up_char == KEYWORD[ST_LAST])
      // A stray G restarts the keyword
      next_state = ST_IDLE + 3'd1;
    else
      next_state = ST_IDLE;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cur_state    <= ST_IDLE;
      out_beat.vld <= 1'b0;
      wb.we        <= 1'b0;
    end
    else
    begin
      out_beat.vld <= in_beat.beat.vld;
      // Save state at the end of an enabled packet
      wb.we <= in_beat.beat.vld && in_beat.beat.eop && in_beat.beat.enable;
      if (in_beat.beat.vld)
        cur_state <= next_state;

      // Payload
      out_beat.sop        <= in_beat.beat.sop;
      out_beat.eop        <= in_beat.beat.eop;
      out_beat.stream     <= in_beat.beat.stream;
      out_beat.enable     <= in_beat.beat.enable;
      out_beat.accept     <= accept;
      out_beat.next_state <= next_state;
      wb.stream           <= in_beat.beat.stream;
      wb.state            <= next_state;
    end
  end

endmodule

// File: stream_context.sv
`timescale 1ns/1ps

module stream_context (
  input  logic                clk,
  input  logic                rst_n,
  input  scan_pkg::beat_t     in_beat,
  input  scan_pkg::state_wb_t wb,
  output scan_pkg::ctx_beat_t out_beat
);
  import scan_pkg::*;

  // Saved DFA state per stream
  dfa_state_t state_mem [NUM_STREAMS];

  // Input capture, first half of stage 1
  beat_t in_r;

  // Previous packet tracking
  logic                prev_vld;
  logic [STREAM_W-1:0] prev_stream;
  logic                prev_enable;

  // Memory word with a same-cycle write forwarded
  dfa_state_t saved_state;
  // Previous packet's end state is still live in the DFA
  logic       resume_now;
  logic       sop_now;

  always_comb
  begin
    sop_now = in_r.vld && in_r.sop;
    // A write landing on this edge is newer than the memory word
    if (wb.we && wb.stream == in_r.stream)
      saved_state = wb.state;
    else
      saved_state = state_mem[in_r.stream];
    resume_now = prev_vld && prev_enable && (prev_stream == in_r.stream) &&
                 !in_r.new_stream;
  end

  // State save from stage 2
  always_ff @(posedge clk)
  begin
    if (wb.we)
      state_mem[wb.stream] <= wb.state;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      in_r.vld         <= 1'b0;
      out_beat.beat.vld <= 1'b0;
      prev_vld         <= 1'b0;
    end
    else
    begin
      in_r          <= in_beat;
      out_beat.beat <= in_r;
      // Starting state only matters on sop
      if (sop_now)
      begin
        out_beat.resume <= resume_now;
        if (in_r.new_stream)
          out_beat.start_state <= ST_IDLE;
        else
          out_beat.start_state <= saved_state;
        // Remember this packet for the next one
        prev_vld    <= 1'b1;
        prev_stream <= in_r.stream;
        prev_enable <= in_r.enable;
      end
    end
  end

endmodule

// File: scan_pkg.sv
package scan_pkg;

  // Stream id width and depth of the per-stream state memory
  localparam int STREAM_W    = 6;
  localparam int NUM_STREAMS = 64;

  // DFA state, 0 is idle and 1..5 count keyword characters seen
  typedef logic [2:0] dfa_state_t;

  localparam dfa_state_t ST_IDLE = 3'd0;
  // Last partial state, the next byte must be the closing space
  localparam dfa_state_t ST_LAST = 3'd5;

  // Upper case keyword, first character in the top byte
  localparam logic [5:0][7:0] KEYWORD = "GROUP ";

  // One input beat
  typedef struct packed {
    logic                vld;
    logic [7:0]          data;
    logic                sop;
    logic                eop;
    logic [STREAM_W-1:0] stream;
    logic                new_stream;
    logic                enable;
  } beat_t;

  // Stage 1 output, beat plus the packet's starting state
  typedef struct packed {
    beat_t      beat;
    dfa_state_t start_state;
    logic       resume;
  } ctx_beat_t;

  // Stage 2 output
  typedef struct packed {
    logic                vld;
    logic                sop;
    logic                eop;
    logic [STREAM_W-1:0] stream;
    logic                enable;
    logic                accept;
    dfa_state_t          next_state;
  } dfa_beat_t;

  // End of packet state save
  typedef struct packed {
    logic                we;
    logic [STREAM_W-1:0] stream;
    dfa_state_t          state;
  } state_wb_t;

  // End of packet report
  typedef struct packed {
    logic                vld;
    logic [STREAM_W-1:0] stream;
    logic                matched;
  } result_t;

endpackage
